// ==== rtl/cdl_pkg.sv ====
`default_nettype none

package cdl_pkg;

  // memory geometry.
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  // latency setting and window counter width.
  localparam int LAT_W = 32;

  // command queue.
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // memory delay counter, holds delay minus one.
  localparam int DELAY_W = 3;

  localparam int STALL_W = 16;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cdl_op_e;

  typedef enum logic [1:0] {
    ST_READY      = 2'd0,
    ST_BUSY       = 2'd1,
    ST_WAIT_DATA  = 2'd2,
    ST_WAIT_TIMER = 2'd3
  } cdl_state_e;

endpackage

`default_nettype wire

// ==== rtl/cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo (
  input  wire logic                         ds_clk_i,
  input  wire logic                         ds_reset_i,
  input  wire logic                         push_i,
  input  wire cdl_pkg::cdl_op_e             push_op_i,
  input  wire logic [cdl_pkg::ADDR_W-1:0]   push_addr_i,
  input  wire logic [cdl_pkg::DATA_W-1:0]   push_data_i,
  input  wire logic                         deq_i,
  input  wire logic                         sink_ready_i,
  output logic                              not_full_o,
  output logic                              fire_o,
  output cdl_pkg::cdl_op_e                  head_op_o,
  output logic [cdl_pkg::ADDR_W-1:0]        head_addr_o,
  output logic [cdl_pkg::DATA_W-1:0]        head_data_o
);

  import cdl_pkg::*;

  cdl_op_e           op_q   [FIFO_DEPTH];
  logic [ADDR_W-1:0] addr_q [FIFO_DEPTH];
  logic [DATA_W-1:0] data_q [FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr_r;
  logic [FIFO_PTR_W-1:0] rd_ptr_r;
  logic [FIFO_PTR_W:0]   count_r;
  logic                  push_w;

  assign not_full_o = (count_r != FIFO_DEPTH);
  assign push_w     = push_i & not_full_o; // push into a full queue is dropped.

  // dispatch needs an entry plus both permissions.
  assign fire_o = (count_r != '0) & deq_i & sink_ready_i;

  assign head_op_o   = op_q[rd_ptr_r];
  assign head_addr_o = addr_q[rd_ptr_r];
  assign head_data_o = data_q[rd_ptr_r];

  always_ff @(posedge ds_clk_i) begin
    if (push_w) begin
      op_q[wr_ptr_r]   <= push_op_i;
      addr_q[wr_ptr_r] <= push_addr_i;
      data_q[wr_ptr_r] <= push_data_i;
    end
  end

  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push_w) begin
        wr_ptr_r <= wr_ptr_r + 1'b1; // depth is a power of two, pointer wraps.
      end
      if (fire_o) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      case ({push_w, fire_o})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r; // both or neither.
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cdl_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdl_ctrl (
  input  wire logic                        ds_clk_i,
  input  wire logic                        ds_reset_i,
  input  wire logic                        en_i,
  input  wire logic [cdl_pkg::LAT_W-1:0]   lat_i,
  input  wire logic                        cmd_v_i,
  input  wire logic                        resp_v_i,
  output logic                             deq_o,
  output logic                             gate_o,
  output logic [cdl_pkg::STALL_W-1:0]      stall_cnt_o
);

  import cdl_pkg::*;

  cdl_state_e         state_r;
  cdl_state_e         state_n;
  logic               cnt_up_r;
  logic [LAT_W-1:0]   cnt_r;
  logic               start_w;
  logic               end_w;
  logic               counting_w;
  logic               gate_r;
  logic [STALL_W-1:0] stall_r;

  assign start_w    = en_i & cmd_v_i;
  assign end_w      = en_i & (cnt_r == lat_i); // window end, lat_i is at least one.
  assign counting_w = start_w | cnt_up_r;     // count from the fire cycle itself.

  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      cnt_up_r <= 1'b0;
      cnt_r    <= '0;
    end else begin
      if (start_w | end_w) begin
        cnt_up_r <= start_w;
      end
      if (end_w) begin
        cnt_r <= '0;
      end else if (counting_w) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      ST_READY: begin
        if (start_w) state_n = ST_BUSY;
      end
      ST_BUSY: begin
        if (resp_v_i && end_w) begin
          state_n = ST_READY;
        end else if (resp_v_i) begin
          state_n = ST_WAIT_TIMER; // data came back inside the window.
        end else if (end_w) begin
          state_n = ST_WAIT_DATA;
        end
      end
      ST_WAIT_TIMER: begin
        if (end_w) state_n = ST_READY;
      end
      ST_WAIT_DATA: begin
        if (resp_v_i) state_n = ST_READY;
      end
      default: state_n = ST_READY;
    endcase
  end

  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      state_r <= ST_READY;
    end else begin
      state_r <= state_n;
    end
  end

  // next state as registered, keeps fire out of its own permission.
  assign deq_o = en_i ? (state_r == ST_READY) : 1'b1;

  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      gate_r  <= 1'b0;
      stall_r <= '0;
    end else begin
      gate_r <= en_i & (state_n == ST_WAIT_DATA);
      if (gate_r && (stall_r != {STALL_W{1'b1}})) begin
        stall_r <= stall_r + 1'b1; // saturates.
      end
    end
  end

  assign gate_o      = gate_r;
  assign stall_cnt_o = stall_r;

endmodule

`default_nettype wire

// ==== rtl/mem_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_responder (
  input  wire logic                        ds_clk_i,
  input  wire logic                        ds_reset_i,
  input  wire logic                        cmd_v_i,
  input  wire cdl_pkg::cdl_op_e            cmd_op_i,
  input  wire logic [cdl_pkg::ADDR_W-1:0]  cmd_addr_i,
  input  wire logic [cdl_pkg::DATA_W-1:0]  cmd_data_i,
  output logic                             ready_o,
  output logic                             resp_v_o,
  output logic [cdl_pkg::DATA_W-1:0]       resp_data_o
);

  import cdl_pkg::*;

  localparam int WORDS = 2 ** ADDR_W;

  logic [DATA_W-1:0]  mem_q [WORDS];
  logic [WORDS-1:0]   written_r;
  logic [7:0]         lfsr_r;
  logic               lfsr_fb_w;
  logic               busy_r;
  logic [DELAY_W-1:0] delay_r;
  logic [DATA_W-1:0]  data_r;
  logic               accept_w;
  logic               is_write_w;
  logic [DATA_W-1:0]  rd_word_w;

  assign ready_o    = ~busy_r;
  assign accept_w   = cmd_v_i & ready_o;
  assign is_write_w = (cmd_op_i == OP_WRITE);

  // x^8 + x^6 + x^5 + x^4 + 1.
  assign lfsr_fb_w = lfsr_r[7] ^ lfsr_r[5] ^ lfsr_r[4] ^ lfsr_r[3];

  // never written words read back as zero.
  assign rd_word_w = written_r[cmd_addr_i] ? mem_q[cmd_addr_i] : '0;

  always_ff @(posedge ds_clk_i) begin
    if (accept_w && is_write_w) begin
      mem_q[cmd_addr_i] <= cmd_data_i;
    end
  end

  always_ff @(posedge ds_clk_i) begin
    if (accept_w) begin
      data_r <= is_write_w ? cmd_data_i : rd_word_w; // writes echo their data.
    end
  end

  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      lfsr_r    <= 8'hA5;
      written_r <= '0;
    end else begin
      lfsr_r <= {lfsr_r[6:0], lfsr_fb_w};
      if (accept_w && is_write_w) begin
        written_r[cmd_addr_i] <= 1'b1;
      end
    end
  end

  // delay_r holds cycles left minus one, so 0..7 covers 1..8.
  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      busy_r  <= 1'b0;
      delay_r <= '0;
    end else if (accept_w) begin
      busy_r  <= 1'b1;
      delay_r <= lfsr_r[DELAY_W-1:0];
    end else if (busy_r) begin
      if (delay_r == '0) begin
        busy_r <= 1'b0; // response cycle.
      end else begin
        delay_r <= delay_r - 1'b1;
      end
    end
  end

  assign resp_v_o    = busy_r & (delay_r == '0);
  assign resp_data_o = data_r;

endmodule

`default_nettype wire

// ==== rtl/cdl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdl_top (
  input  wire logic                        ds_clk_i,
  input  wire logic                        ds_reset_i,
  input  wire logic                        en_i,
  input  wire logic [cdl_pkg::LAT_W-1:0]   lat_i,
  input  wire logic                        req_v_i,
  input  wire cdl_pkg::cdl_op_e            req_op_i,
  input  wire logic [cdl_pkg::ADDR_W-1:0]  req_addr_i,
  input  wire logic [cdl_pkg::DATA_W-1:0]  req_data_i,
  output logic                             req_ready_o,
  output logic                             rsp_v_o,
  output logic [cdl_pkg::DATA_W-1:0]       rsp_data_o,
  output logic                             gate_o,
  output logic [cdl_pkg::STALL_W-1:0]      stall_cnt_o
);

  import cdl_pkg::*;

  logic              fire_w;
  logic              deq_w;
  logic              mem_ready_w;
  cdl_op_e           head_op_w;
  logic [ADDR_W-1:0] head_addr_w;
  logic [DATA_W-1:0] head_data_w;

  cmd_fifo u_fifo (
    .ds_clk_i     (ds_clk_i),
    .ds_reset_i   (ds_reset_i),
    .push_i       (req_v_i),
    .push_op_i    (req_op_i),
    .push_addr_i  (req_addr_i),
    .push_data_i  (req_data_i),
    .deq_i        (deq_w),
    .sink_ready_i (mem_ready_w),
    .not_full_o   (req_ready_o),
    .fire_o       (fire_w),
    .head_op_o    (head_op_w),
    .head_addr_o  (head_addr_w),
    .head_data_o  (head_data_w)
  );

  cdl_ctrl u_ctrl (
    .ds_clk_i    (ds_clk_i),
    .ds_reset_i  (ds_reset_i),
    .en_i        (en_i),
    .lat_i       (lat_i),
    .cmd_v_i     (fire_w),
    .resp_v_i    (rsp_v_o),
    .deq_o       (deq_w),
    .gate_o      (gate_o),
    .stall_cnt_o (stall_cnt_o)
  );

  mem_responder u_mem (
    .ds_clk_i    (ds_clk_i),
    .ds_reset_i  (ds_reset_i),
    .cmd_v_i     (fire_w),
    .cmd_op_i    (head_op_w),
    .cmd_addr_i  (head_addr_w),
    .cmd_data_i  (head_data_w),
    .ready_o     (mem_ready_w),
    .resp_v_o    (rsp_v_o),
    .resp_data_o (rsp_data_o)
  );

endmodule

`default_nettype wire

// ==== bench/tb_cdl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cdl_top;

  import cdl_pkg::*;

  localparam int TIMEOUT = 2000;
  localparam int N_CMDS  = 200;
  localparam int DMAX    = 8; // longest memory delay.

  logic               ds_clk_i;
  logic               ds_reset_i;
  logic               en_i;
  logic [LAT_W-1:0]   lat_i;
  logic               req_v_i;
  cdl_op_e            req_op_i;
  logic [ADDR_W-1:0]  req_addr_i;
  logic [DATA_W-1:0]  req_data_i;
  logic               req_ready_o;
  logic               rsp_v_o;
  logic [DATA_W-1:0]  rsp_data_o;
  logic               gate_o;
  logic [STALL_W-1:0] stall_cnt_o;

  integer            seed;
  int                errors;
  int                test_errors;
  int                tests_run;
  int                tests_failed;
  bit                timed_out;
  bit                gate_allowed;
  logic [DATA_W-1:0] model_mem [16]; // only 16 words are addressed.
  logic [DATA_W-1:0] exp_q [$];      // expected responses in push order.
  int                cyc;
  int                outstanding;
  int                accepted;
  int                dropped;
  int                rsp_count;
  int                first_rsp_cyc;
  int                last_rsp_cyc;
  int                min_gap;
  int                gate_high_cnt;
  int                gate_run;
  int                stall_start;
  bit                gate_prev;
  bit                rsp_prev;
  bit                saw_full;

  initial begin
    ds_clk_i = 1'b0;
    forever #10 ds_clk_i = ~ds_clk_i;
  end

  cdl_top uut (
    .ds_clk_i    (ds_clk_i),
    .ds_reset_i  (ds_reset_i),
    .en_i        (en_i),
    .lat_i       (lat_i),
    .req_v_i     (req_v_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .req_ready_o (req_ready_o),
    .rsp_v_o     (rsp_v_o),
    .rsp_data_o  (rsp_data_o),
    .gate_o      (gate_o),
    .stall_cnt_o (stall_cnt_o)
  );

  task automatic note_error(input string msg);
    $display("ERROR: %s (cycle %0d)", msg, cyc);
    errors++;
  endtask

  // outputs are settled at the falling edge.
  always @(negedge ds_clk_i) begin : monitor
    logic [DATA_W-1:0] exp_data;
    int                gap;
    cyc++;
    if (!ds_reset_i) begin
      if (gate_o && !gate_allowed) begin
        $display("[FAIL] gate_o got %h expected %h (cycle %0d)", gate_o, 1'b0, cyc);
        errors++;
      end
      if (gate_o && outstanding == 0) note_error("gate_o is high with no command outstanding");
      if (gate_prev && !rsp_prev && !gate_o) note_error("gate_o fell before the response");
      if (gate_prev && rsp_prev && gate_o) note_error("gate_o stayed high after the response");
      gate_run = gate_o ? gate_run + 1 : 0;
      if (gate_run > DMAX - 1) note_error("gate_o high longer than any memory delay");
      if (!req_ready_o && outstanding < FIFO_DEPTH) begin
        note_error("req_ready_o is low while the queue has room");
      end
      if (outstanding > FIFO_DEPTH + 1) note_error("more commands held than queue and memory fit");
      if (!req_ready_o) saw_full = 1'b1;
      if (gate_o) gate_high_cnt++;
      if (rsp_v_o) begin
        if (exp_q.size() == 0) begin
          note_error("response with no command outstanding");
        end else begin
          exp_data = exp_q.pop_front();
          if (rsp_data_o !== exp_data) begin
            $display("[FAIL] rsp_data_o got %h expected %h (cycle %0d)",
                     rsp_data_o, exp_data, cyc);
            errors++;
          end
        end
        if (rsp_count > 0) begin
          gap = cyc - last_rsp_cyc;
          if (gap < min_gap) begin
            note_error($sformatf("responses %0d cycles apart, minimum is %0d", gap, min_gap));
          end
        end else begin
          first_rsp_cyc = cyc;
        end
        last_rsp_cyc = cyc;
        rsp_count++;
        outstanding--;
      end
      // the push lands at the next rising edge.
      if (req_v_i && req_ready_o) begin
        accepted++;
        outstanding++;
        if (req_op_i == OP_WRITE) begin
          model_mem[req_addr_i[3:0]] = req_data_i;
          exp_q.push_back(req_data_i); // writes echo their data.
        end else begin
          exp_q.push_back(model_mem[req_addr_i[3:0]]);
        end
      end else if (req_v_i) begin
        dropped++;
      end
      gate_prev = gate_o;
      rsp_prev  = rsp_v_o;
    end
  end

  task automatic apply_reset(input bit en, input int lat, input bit gate_ok);
    @(posedge ds_clk_i);
    #2;
    ds_reset_i   = 1'b1;
    req_v_i      = 1'b0;
    en_i         = en;
    lat_i        = lat;
    gate_allowed = gate_ok;
    for (int i = 0; i < 16; i++) begin
      model_mem[i] = '0;
    end
    exp_q.delete();
    outstanding   = 0;
    accepted      = 0;
    dropped       = 0;
    rsp_count     = 0;
    gate_high_cnt = 0;
    gate_run      = 0;
    gate_prev     = 1'b0;
    rsp_prev      = 1'b0;
    saw_full      = 1'b0;
    // next fire waits for both the response and the window end.
    min_gap = (en && lat + 2 - DMAX > 2) ? lat + 2 - DMAX : 2;
    repeat (8) @(posedge ds_clk_i);
    #2;
    ds_reset_i = 1'b0;
    @(negedge ds_clk_i);
    stall_start = stall_cnt_o;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (outstanding != 0 && waited < TIMEOUT) begin
      @(negedge ds_clk_i);
      waited++;
    end
    if (outstanding != 0) begin
      note_error("timeout waiting for responses to drain");
      timed_out = 1'b1;
    end
    repeat (4) @(negedge ds_clk_i);
  endtask

  // hold keeps a command up until accepted, otherwise one new command per cycle.
  task automatic run_traffic(input bit en, input int lat, input bit gate_ok, input bit hold,
                             input int n);
    int k;
    int idle;
    int waited;
    apply_reset(en, lat, gate_ok);
    k = 0;
    while (k < n && !timed_out) begin
      idle = hold ? ($random(seed) & 3) : 0;
      repeat (idle) begin
        @(posedge ds_clk_i);
        #2;
        req_v_i = 1'b0;
      end
      @(posedge ds_clk_i);
      #2;
      req_v_i    = 1'b1;
      req_op_i   = ($random(seed) & 1) ? OP_WRITE : OP_READ;
      req_addr_i = ADDR_W'($random(seed) & 15);
      req_data_i = $random(seed);
      k++;
      if (hold) begin
        waited = 0;
        @(negedge ds_clk_i);
        while (!req_ready_o && waited < TIMEOUT) begin
          @(negedge ds_clk_i);
          waited++;
        end
        if (!req_ready_o) begin
          note_error("timeout waiting for req_ready_o");
          timed_out = 1'b1;
        end
      end
    end
    @(posedge ds_clk_i);
    #2;
    req_v_i = 1'b0;
    wait_drain();
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    int span_min;
    if (rsp_count != accepted) begin
      note_error($sformatf("%0d responses for %0d accepted commands", rsp_count, accepted));
    end
    // over a run the fires are at least lat_i + 1 apart.
    span_min = (int'(lat_i) + 1) * (rsp_count - 1) - (DMAX - 1);
    if (en_i && rsp_count > 1 && last_rsp_cyc - first_rsp_cyc < span_min) begin
      note_error($sformatf("responses span %0d cycles, minimum is %0d",
                           last_rsp_cyc - first_rsp_cyc, span_min));
    end
    report_test(name);
  endtask

  initial begin
    seed         = 32'h887eccaf;
    ds_reset_i   = 1'b1;
    en_i         = 1'b0;
    lat_i        = 1;
    req_v_i      = 1'b0;
    req_op_i     = OP_READ;
    req_addr_i   = '0;
    req_data_i   = '0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    gate_allowed = 1'b0;
    cyc          = 0;

    apply_reset(1'b0, 1, 1'b0);
    if (gate_o !== 1'b0) begin
      $display("[FAIL] gate_o got %h expected %h", gate_o, 1'b0);
      errors++;
    end
    if (rsp_v_o !== 1'b0) begin
      $display("[FAIL] rsp_v_o got %h expected %h", rsp_v_o, 1'b0);
      errors++;
    end
    if (stall_cnt_o !== '0) begin
      $display("[FAIL] stall_cnt_o got %h expected %h", stall_cnt_o, 16'h0);
      errors++;
    end
    if (req_ready_o !== 1'b1) begin
      $display("[FAIL] req_ready_o got %h expected %h", req_ready_o, 1'b1);
      errors++;
    end
    report_test("1 reset state");

    run_traffic(1'b0, 1, 1'b0, 1'b1, N_CMDS);
    end_test("2 data with emulation off");

    if (!timed_out) begin
      run_traffic(1'b1, 12, 1'b0, 1'b1, N_CMDS);
      end_test("3 spacing with lat_i 12");
    end

    if (!timed_out) begin
      run_traffic(1'b1, 1, 1'b1, 1'b1, N_CMDS);
      if (gate_high_cnt == 0) note_error("gate_o never rose with lat_i of one");
      end_test("4 gate with lat_i 1");
      if (int'(stall_cnt_o) != stall_start + gate_high_cnt) begin
        $display("[FAIL] stall_cnt_o got %h expected %h", stall_cnt_o,
                 STALL_W'(stall_start + gate_high_cnt));
        errors++;
      end
      report_test("5 stall count");
    end

    if (!timed_out) begin
      run_traffic(1'b1, 20, 1'b0, 1'b0, N_CMDS);
      if (!saw_full) note_error("req_ready_o never fell during the burst");
      if (dropped == 0) note_error("no push was dropped during the burst");
      end_test("6 back-pressure with lat_i 20");
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/cdl_pkg.sv
rtl/cmd_fifo.sv
rtl/cdl_ctrl.sv
rtl/mem_responder.sv
rtl/cdl_top.sv
bench/tb_cdl_top.sv

// ==== Bender.yml ====
package:
  name: cdl_top

sources:
  - files:
      - rtl/cdl_pkg.sv
      - rtl/cmd_fifo.sv
      - rtl/cdl_ctrl.sv
      - rtl/mem_responder.sv
      - rtl/cdl_top.sv
  - target: simulation
    files:
      - bench/tb_cdl_top.sv
